// File: logic/acq_scheduler.sv
`timescale 1ns/10ps

module acq_scheduler #(
   parameter int FILL_WORDS_LOG2 = 24
) (
   input  logic                                    rst,
   input  logic                                    bb_clk,
   input  logic [tart_acq_pkg::BUF_ADDR_WIDTH-1:0] wr_ptr_bb,
   input  logic [tart_acq_pkg::SAMPLE_WIDTH-1:0]   rd_data,
   input  logic                                    cmd_ready,
   input  logic                                    spi_buffer_read_complete,
   output logic [tart_acq_pkg::BUF_ADDR_WIDTH-1:0] rd_addr,
   output logic                                    cmd_enable,
   output tart_acq_pkg::sdram_cmd_t                cmd,
   output tart_acq_pkg::acq_state_t                acq_state
);
   import tart_acq_pkg::*;

   // one extra bit whose msb flags full (fill) or done (read)
   logic [FILL_WORDS_LOG2:0] fill_ptr;
   logic [FILL_WORDS_LOG2:0] read_ptr;

   logic fire_write;
   logic fire_read;

   assign fire_write = (acq_state == aq_buffer_to_sdram) && cmd_ready;
   assign fire_read  = (acq_state == tx_writing) && cmd_ready;

   always_ff @(posedge bb_clk or posedge rst)
   begin
      if (rst)
      begin
         acq_state  <= aq_waiting;
         cmd_enable <= 1'b0;
         rd_addr    <= '0;
         fill_ptr   <= '0;
         read_ptr   <= '0;
      end
      else
      begin
         // enable is a single cycle pulse
         cmd_enable <= 1'b0;
         case (acq_state)
            aq_waiting:
            begin
               if (fill_ptr[FILL_WORDS_LOG2])
                  acq_state <= tx_writing;
               else if (rd_addr != wr_ptr_bb)
                  acq_state <= aq_buffer_to_sdram;
            end
            aq_buffer_to_sdram:
            begin
               if (fire_write)
               begin
                  cmd_enable <= 1'b1;
                  rd_addr    <= rd_addr + 1'b1;
                  fill_ptr   <= fill_ptr + 1'b1;
                  acq_state  <= aq_waiting;
               end
            end
            tx_writing:
            begin
               if (fire_read)
               begin
                  cmd_enable <= 1'b1;
                  read_ptr   <= read_ptr + 1'b1;
                  acq_state  <= tx_idle;
               end
            end
            tx_idle:
            begin
               if (read_ptr[FILL_WORDS_LOG2])
                  acq_state <= finished;
               else if (spi_buffer_read_complete)
                  acq_state <= tx_writing;
            end
            finished:
            begin
               acq_state <= finished;
            end
            default:
            begin
               acq_state <= aq_waiting;
            end
         endcase
      end
   end

   // command payload captured alongside the enable pulse
   always_ff @(posedge bb_clk)
   begin
      if (fire_write)
      begin
         cmd.wr      <= 1'b1;
         cmd.address <= SDRAM_ADDR_WIDTH'(fill_ptr[FILL_WORDS_LOG2-1:0]);
         cmd.data    <= SDRAM_DATA_WIDTH'(rd_data);
      end
      else if (fire_read)
      begin
         cmd.wr      <= 1'b0;
         cmd.address <= SDRAM_ADDR_WIDTH'(read_ptr[FILL_WORDS_LOG2-1:0]);
         cmd.data    <= '0;
      end
   end

   // sdram side expects a gap after every command
   cmd_single_pulse: assert property (@(posedge bb_clk) disable iff (rst)
      cmd_enable |=> !cmd_enable);

   // no commands once finished
   finished_quiet: assert property (@(posedge bb_clk) disable iff (rst)
      (acq_state == finished) |-> !cmd_enable);

endmodule

// File: logic/readout_capture.sv
`timescale 1ns/10ps

module readout_capture (
   input  logic                                      rst,
   input  logic                                      bb_clk,
   input  tart_acq_pkg::sdram_rdback_t               rdback,
   input  logic                                      spi_buffer_read_complete,
   output logic [tart_acq_pkg::SDRAM_DATA_WIDTH-1:0] tx_word,
   output logic                                      tx_valid
);

   // hold the returned word for the spi shifter
   always_ff @(posedge bb_clk)
   begin
      if (rdback.valid)
         tx_word <= rdback.data;
   end

   // level stays up until the spi side has shifted the word out
   always_ff @(posedge bb_clk or posedge rst)
   begin
      if (rst)
      begin
         tx_valid <= 1'b0;
      end
      else
      begin
         if (rdback.valid)
            tx_valid <= 1'b1;
         else if (spi_buffer_read_complete)
            tx_valid <= 1'b0;
      end
   end

   // scheduler only issues the next read after the spi side released the word,
   // so new data must never land on a word still being sent
   no_overwrite: assert property (@(posedge bb_clk) disable iff (rst)
      tx_valid |-> !rdback.valid);

endmodule

// File: logic/sample_buffer.sv
`timescale 1ns/10ps

module sample_buffer (
   input  logic                                    rst,
   input  logic                                    write_clk,
   input  logic                                    bb_clk,
   input  logic                                    spi_start_aq,
   input  logic [tart_acq_pkg::SAMPLE_WIDTH-1:0]   sample,
   input  logic [tart_acq_pkg::BUF_ADDR_WIDTH-1:0] rd_addr,
   output logic [tart_acq_pkg::SAMPLE_WIDTH-1:0]   rd_data,
   output logic [tart_acq_pkg::BUF_ADDR_WIDTH-1:0] wr_ptr_bb
);
   import tart_acq_pkg::*;

   localparam int DEPTH = 2 ** BUF_ADDR_WIDTH;

   logic [SAMPLE_WIDTH-1:0]   mem [DEPTH];
   logic [1:0]                start_sync;
   logic [BUF_ADDR_WIDTH-1:0] wr_addr;
   logic [BUF_ADDR_WIDTH-1:0] wr_addr_next;
   logic [BUF_ADDR_WIDTH-1:0] wr_gray;
   logic [BUF_ADDR_WIDTH-1:0] gray_meta;
   logic [BUF_ADDR_WIDTH-1:0] gray_bb;

   function automatic logic [BUF_ADDR_WIDTH-1:0] gray_to_bin(
      input logic [BUF_ADDR_WIDTH-1:0] g
   );
      logic [BUF_ADDR_WIDTH-1:0] b;
      b[BUF_ADDR_WIDTH-1] = g[BUF_ADDR_WIDTH-1];
      for (int i = BUF_ADDR_WIDTH - 2; i >= 0; i--)
      begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   assign wr_addr_next = wr_addr + 1'b1;

   // start level is asynchronous to write_clk, two flops before use
   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
      begin
         start_sync <= 2'b00;
         wr_addr    <= '0;
         wr_gray    <= '0;
      end
      else
      begin
         start_sync <= {start_sync[0], spi_start_aq};
         if (start_sync[1])
         begin
            wr_addr <= wr_addr_next;
            // gray copy moves together with the binary counter
            wr_gray <= wr_addr_next ^ (wr_addr_next >> 1);
         end
      end
   end

   always_ff @(posedge write_clk)
   begin
      if (start_sync[1])
         mem[wr_addr] <= sample;
   end

   // pointer crossing into bb_clk
   always_ff @(posedge bb_clk or posedge rst)
   begin
      if (rst)
      begin
         gray_meta <= '0;
         gray_bb   <= '0;
      end
      else
      begin
         gray_meta <= wr_gray;
         gray_bb   <= gray_meta;
      end
   end

   always_comb wr_ptr_bb = gray_to_bin(gray_bb);

   // registered read port, data one cycle after rd_addr
   always_ff @(posedge bb_clk)
   begin
      rd_data <= mem[rd_addr];
   end

   // the synchronizer only sees a safe value if a single bit flips per write
   gray_one_bit_step: assert property (@(posedge write_clk) disable iff (rst)
      $countones(wr_gray ^ $past(wr_gray)) <= 1);

endmodule

// File: logic/tart_acq_pkg.sv
package tart_acq_pkg;

   // antenna sample and sample buffer geometry
   localparam int SAMPLE_WIDTH   = 24;
   localparam int BUF_ADDR_WIDTH = 9;

   // sdram command port
   localparam int SDRAM_ADDR_WIDTH = 24;
   localparam int SDRAM_DATA_WIDTH = 32;

   typedef enum logic [2:0] {
      aq_waiting         = 3'd0,
      aq_buffer_to_sdram = 3'd1,
      tx_writing         = 3'd2,
      tx_idle            = 3'd3,
      finished           = 3'd4
   } acq_state_t;

   // only meaningful while cmd_enable is high
   typedef struct packed {
      logic                        wr;
      logic [SDRAM_ADDR_WIDTH-1:0] address;
      logic [SDRAM_DATA_WIDTH-1:0] data;
   } sdram_cmd_t;

   // read data, valid for a single cycle
   typedef struct packed {
      logic                        valid;
      logic [SDRAM_DATA_WIDTH-1:0] data;
   } sdram_rdback_t;

endpackage

// File: logic/tart_acq_top.sv
`timescale 1ns/10ps

module tart_acq_top #(
   parameter int FILL_WORDS_LOG2 = 24
) (
   input  logic                                      rst,
   input  logic                                      bb_clk,
   input  logic                                      write_clk,

   // acquisition side
   input  logic [tart_acq_pkg::SAMPLE_WIDTH-1:0]     sample,
   input  logic                                      spi_start_aq,

   // sdram command port
   input  logic                                      cmd_ready,
   output logic                                      cmd_enable,
   output tart_acq_pkg::sdram_cmd_t                  cmd,
   input  tart_acq_pkg::sdram_rdback_t               rdback,

   // spi transmit side
   output logic [tart_acq_pkg::SDRAM_DATA_WIDTH-1:0] tx_word,
   output logic                                      tx_valid,
   input  logic                                      spi_buffer_read_complete,

   output tart_acq_pkg::acq_state_t                  acq_state
);
   import tart_acq_pkg::*;

   logic [BUF_ADDR_WIDTH-1:0] wr_ptr_bb;
   logic [BUF_ADDR_WIDTH-1:0] rd_addr;
   logic [SAMPLE_WIDTH-1:0]   rd_data;

   sample_buffer sample_buffer_i (
      .rst          (rst),
      .write_clk    (write_clk),
      .bb_clk       (bb_clk),
      .spi_start_aq (spi_start_aq),
      .sample       (sample),
      .rd_addr      (rd_addr),
      .rd_data      (rd_data),
      .wr_ptr_bb    (wr_ptr_bb)
   );

   acq_scheduler #(
      .FILL_WORDS_LOG2 (FILL_WORDS_LOG2)
   ) acq_scheduler_i (
      .rst                      (rst),
      .bb_clk                   (bb_clk),
      .wr_ptr_bb                (wr_ptr_bb),
      .rd_data                  (rd_data),
      .cmd_ready                (cmd_ready),
      .spi_buffer_read_complete (spi_buffer_read_complete),
      .rd_addr                  (rd_addr),
      .cmd_enable               (cmd_enable),
      .cmd                      (cmd),
      .acq_state                (acq_state)
   );

   readout_capture readout_capture_i (
      .rst                      (rst),
      .bb_clk                   (bb_clk),
      .rdback                   (rdback),
      .spi_buffer_read_complete (spi_buffer_read_complete),
      .tx_word                  (tx_word),
      .tx_valid                 (tx_valid)
   );

endmodule

// File: sim.f
logic/tart_acq_pkg.sv
logic/sample_buffer.sv
logic/acq_scheduler.sv
logic/readout_capture.sv
logic/tart_acq_top.sv
testbench/sdram_model.sv
testbench/tb_tart_acq.sv

// File: testbench/sdram_model.sv
`timescale 1ns/10ps

module sdram_model #(
   parameter int ADDR_BITS = 5
) (
   input  logic                        bb_clk,
   input  logic [31:0]                 noise,
   input  logic                        cmd_enable,
   input  tart_acq_pkg::sdram_cmd_t    cmd,
   output logic                        cmd_ready,
   output tart_acq_pkg::sdram_rdback_t rdback
);
   import tart_acq_pkg::*;

   logic [SDRAM_DATA_WIDTH-1:0] mem [2 ** ADDR_BITS];
   logic [SDRAM_DATA_WIDTH-1:0] read_word;
   int                          stall_left;
   int                          read_wait;

   initial
   begin
      cmd_ready  = 1'b0;
      rdback     = '0;
      stall_left = 0;
      read_wait  = 0;
   end

   // commands are stable on the falling edge and outputs move there too
   always @(negedge bb_clk)
   begin
      rdback.valid <= 1'b0;
      // data bus carries junk between returns
      rdback.data  <= noise;
      if (read_wait == 1)
      begin
         rdback.valid <= 1'b1;
         rdback.data  <= read_word;
      end
      if (read_wait > 0)
         read_wait <= read_wait - 1;
      if (cmd_enable && cmd.wr)
         mem[cmd.address[ADDR_BITS-1:0]] <= cmd.data;
      else if (cmd_enable)
      begin
         read_word <= mem[cmd.address[ADDR_BITS-1:0]];
         // latency of 2 to 5 cycles
         read_wait <= 2 + int'(noise[1:0]);
      end
      if (stall_left > 0)
      begin
         cmd_ready  <= 1'b0;
         stall_left <= stall_left - 1;
      end
      else if (noise[7:5] == 3'd0)
      begin
         // back-pressure stretch of 1 to 8 cycles
         cmd_ready  <= 1'b0;
         stall_left <= int'(noise[10:8]);
      end
      else
         cmd_ready <= 1'b1;
   end

endmodule

// File: testbench/tb_tart_acq.sv
`timescale 1ns/10ps

module tb_tart_acq;
   import tart_acq_pkg::*;

   localparam int FILL_WORDS_LOG2 = 5;
   localparam int FILL_WORDS      = 2 ** FILL_WORDS_LOG2;
   // the start synchronizer lets two write_clk edges pass before the first store
   localparam int SYNC_STAGES     = 2;
   localparam int N_SAMPLES       = FILL_WORDS + 8;
   // about 100 cycles to fill plus about 15 per word read out and a wide margin
   localparam int TIMEOUT_CYCLES  = 4000;

   logic                        rst;
   logic                        bb_clk;
   logic                        write_clk;
   logic [SAMPLE_WIDTH-1:0]     sample;
   logic                        spi_start_aq;
   logic                        cmd_ready;
   logic                        cmd_enable;
   sdram_cmd_t                  cmd;
   sdram_rdback_t               rdback;
   logic [SDRAM_DATA_WIDTH-1:0] tx_word;
   logic                        tx_valid;
   logic                        spi_buffer_read_complete;
   acq_state_t                  acq_state;
   logic [31:0]                 noise;

   logic [SAMPLE_WIDTH-1:0] samples [N_SAMPLES];
   int unsigned             addr_q [$];
   int                      errors;
   int                      errors_reported;
   int                      write_count;
   int                      read_count;
   int                      tx_count;
   int                      cycle_count;
   logic                    complete_seen;
   logic                    tx_valid_q;

   tart_acq_top #(.FILL_WORDS_LOG2 (FILL_WORDS_LOG2)) tart_acq_top_i (.*);
   sdram_model #(.ADDR_BITS (FILL_WORDS_LOG2)) sdram_model_i (.*);

   always #20 bb_clk = ~bb_clk;
   always #30 write_clk = ~write_clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // address k holds the sample presented SYNC_STAGES edges after the start edge
   function automatic logic [31:0] expected_word(input int unsigned addr);
      return 32'(samples[addr + SYNC_STAGES]);
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("Error: %s = 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
      errors++;
   endtask

   task automatic report_failure(input string what);
      $display("check failed at %0t ns: %s", $time, what);
      errors++;
   endtask

   task automatic print_test_result(input int num, input string name);
      $display("test %0d %s: %0d errors", num, name, errors - errors_reported);
      errors_reported = errors;
   endtask

   cmd_after_ready: assert property (@(posedge bb_clk) disable iff (rst)
      cmd_enable |-> $past(cmd_ready))
      else report_failure("cmd_enable rose without cmd_ready in the cycle before");

   cmd_one_cycle: assert property (@(posedge bb_clk) disable iff (rst)
      cmd_enable |=> !cmd_enable)
      else report_failure("cmd_enable stayed high for two cycles");

   tx_word_held: assert property (@(posedge bb_clk) disable iff (rst)
      tx_valid && $past(tx_valid) |-> $stable(tx_word))
      else report_failure("tx_word changed while tx_valid was high");

   finished_silent: assert property (@(posedge bb_clk) disable iff (rst)
      (acq_state == finished) |-> !cmd_enable)
      else report_failure("command issued in the finished state");

   // scoreboard on every command and every new transmit word
   always @(posedge bb_clk)
   begin : scoreboard
      int unsigned addr;
      noise <= xorshift32(noise);
      if (!rst && cmd_enable && cmd.wr)
      begin
         assert (write_count < FILL_WORDS)
            else report_failure("write command after all words were filled");
         assert (cmd.address == write_count)
            else report_mismatch("cmd.address", cmd.address, write_count);
         assert (cmd.data == expected_word(write_count))
            else report_mismatch("cmd.data", cmd.data, expected_word(write_count));
         write_count++;
      end
      else if (!rst && cmd_enable)
      begin
         assert (write_count == FILL_WORDS)
            else report_failure("read command before all words were written");
         assert (read_count == 0 || complete_seen)
            else report_failure("read command without a read-complete pulse before it");
         assert (cmd.address == read_count)
            else report_mismatch("cmd.address", cmd.address, read_count);
         addr_q.push_back(read_count);
         read_count++;
         complete_seen = 1'b0;
      end
      if (spi_buffer_read_complete)
         complete_seen = 1'b1;
      if (tx_valid && !tx_valid_q)
      begin
         if (addr_q.size() == 0)
            report_failure("tx_valid rose with no read outstanding");
         else
         begin
            addr = addr_q.pop_front();
            assert (tx_word == expected_word(addr))
               else report_mismatch("tx_word", tx_word, expected_word(addr));
         end
         tx_count++;
      end
      tx_valid_q = tx_valid;
   end

   // spi side releases each word a few cycles after it is offered
   initial
   begin : spi_side
      int n;
      n = 0;
      forever
      begin
         @(negedge bb_clk);
         if (tx_valid === 1'b1)
         begin
            repeat (1 + n % 4) @(negedge bb_clk);
            spi_buffer_read_complete = 1'b1;
            @(negedge bb_clk);
            spi_buffer_read_complete = 1'b0;
            n++;
         end
      end
   end

   initial
   begin : watchdog
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES)
      begin
         @(posedge bb_clk);
         cycle_count++;
      end
      $display("timeout: run did not complete within %0d bb_clk cycles", TIMEOUT_CYCLES);
      $display("Some tests failed");
      $finish;
   end

   initial
   begin : main_flow
      logic [31:0] x;
      int          cmds_at_finish;
      rst = 1'b1;
      bb_clk = 1'b0;
      write_clk = 1'b0;
      sample = '0;
      spi_start_aq = 1'b0;
      spi_buffer_read_complete = 1'b0;
      errors = 0;
      errors_reported = 0;
      write_count = 0;
      read_count = 0;
      tx_count = 0;
      complete_seen = 1'b0;
      tx_valid_q = 1'b0;
      x = 32'd69;
      for (int i = 0; i < N_SAMPLES; i++)
      begin
         x = xorshift32(x);
         samples[i] = x[SAMPLE_WIDTH-1:0];
      end
      // sdram back-pressure and latency continue the same sequence
      noise = xorshift32(x);
      repeat (3) @(negedge bb_clk);
      rst = 1'b0;

      @(negedge bb_clk);
      assert (cmd_enable == 1'b0)
         else report_mismatch("cmd_enable", cmd_enable, 0);
      assert (tx_valid == 1'b0)
         else report_mismatch("tx_valid", tx_valid, 0);
      assert (acq_state == aq_waiting)
         else report_mismatch("acq_state", acq_state, aq_waiting);
      print_test_result(1, "reset state");

      for (int i = 0; i < N_SAMPLES; i++)
      begin
         @(negedge write_clk);
         spi_start_aq = 1'b1;
         sample = samples[i];
      end
      @(negedge write_clk);
      spi_start_aq = 1'b0;
      wait (write_count == FILL_WORDS);
      print_test_result(2, "sample writes");

      wait (read_count == FILL_WORDS);
      print_test_result(3, "read command order");
      wait (tx_count == FILL_WORDS);
      print_test_result(4, "transmit words");

      wait (acq_state == finished);
      cmds_at_finish = write_count + read_count;
      repeat (20) @(negedge bb_clk);
      assert (write_count + read_count == cmds_at_finish)
         else report_failure("command issued after reaching finished");
      print_test_result(5, "finished state");

      $display("writes %0d, reads %0d, words checked %0d, errors %0d",
               write_count, read_count, tx_count, errors);
      if (errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule
